// ==== tests/mmu_trace.txt ====
# C satp_ppn priv sum mxr | W word_addr pte | F = tlb flush
# T name kind vaddr fault paddr hit, numbers in hex, hit 1 = answered one cycle after acceptance
# root table, page 1
W 200 801
W 201 500000cf
W 202 500004cf
W 203 ce
W 204 600000c5
W 205 1001
# level 1 table, page 2
W 400 c01
W 401 a800cf
W 402 a804cf
W 403 b000d7
# level 0 table, page 3
W 601 48d14c7
W 602 88888df
W 603 cccccc7
W 604 111110c9
W 605 15555447
W 606 19999887
W 607 1ddddcc7
# pages 4 and 5 end in a pointer at level 0
W 800 1401
W a00 1801
C 1 1 0 0
T walk_4k load 1abc 0 12345abc 0
T hit_4k load 1abc 0 12345abc 1
T hit_4k_store store 1abc 0 12345abc 1
T mega_load load 255123 0 2a55123 0
T mega_hit_fetch fetch 2aa001 0 2aaa001 1
T giga_load load 52345678 0 152345678 0
T mega_misaligned load 400000 1 0 0
T giga_misaligned load 80001000 1 0 0
T pte_invalid load c0000000 1 0 0
T pte_w_no_r load 100000000 1 0 0
T l0_non_leaf load 140000000 1 0 0
T user_no_sum load 2010 1 0 0
T store_d_clear store 5040 1 0 0
T load_a_clear load 6050 1 0 0
T fetch_no_x fetch 7060 1 0 0
T xonly_no_mxr load 4030 1 0 0
T xonly_no_mxr_again load 4030 1 0 0
F
T flush_walk_4k load 1abc 0 12345abc 0
T flush_hit_4k load 1abc 0 12345abc 1
C 1 1 1 1
T user_sum load 2010 0 22222010 0
T xonly_mxr load 4030 0 44444030 0
T xonly_mxr_rewalk load 4030 0 44444030 0
F
C 1 0 0 0
T sup_from_user load 3020 1 0 0
T user_page_u load 2010 0 22222010 0
T user_mega_store store 607010 0 2c07010 0
T user_mega_hit load 6ff333 0 2cff333 1

// ==== sources.f ====
hw/ptw_pkg.sv
hw/pt_mem.sv
hw/tlb.sv
hw/ptw_walker.sv
hw/mmu_top.sv
tests/mmu_assertions.sv
tests/tb_mmu.sv

// ==== Bender.yml ====
package:
  name: mmu_sv39

sources:
  - hw/ptw_pkg.sv
  - hw/pt_mem.sv
  - hw/tlb.sv
  - hw/ptw_walker.sv
  - hw/mmu_top.sv
  - target: test
    files:
      - tests/mmu_assertions.sv
      - tests/tb_mmu.sv

// ==== tests/tb_mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mmu
  import ptw_pkg::*;
();

  localparam int CLK_HALF_NS       = 10;
  localparam int DRIVE_DELAY_NS    = 2;
  localparam int RESET_CYCLES      = 5;
  localparam int CYCLES_PER_RECORD = 40;
  localparam int LINE_W            = 8*160;
  localparam int TOKEN_W           = 8*32;
  localparam     TRACE_FILE        = "tests/mmu_trace.txt";

  logic              clk_i;
  logic              reset_i;
  logic [PPN_W-1:0]  satp_ppn;
  logic [PRIV_W-1:0] priv_mode;
  logic              sum;
  logic              mxr;
  logic              tlb_flush;
  xlate_req_t        xlate_req;
  logic              xlate_ready;
  xlate_resp_t       xlate_resp;
  pte_wr_t           pte_wr;
  logic              busy;

  logic [LINE_W-1:0] rec_q [$];  // trace records without comments.
  int unsigned       cycle_cnt   = 0;
  int unsigned       cycle_limit = 0;

  mmu_top mmu_top_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .satp_ppn_i    (satp_ppn),
    .priv_mode_i   (priv_mode),
    .sum_i         (sum),
    .mxr_i         (mxr),
    .tlb_flush_i   (tlb_flush),
    .xlate_req_i   (xlate_req),
    .xlate_ready_o (xlate_ready),
    .xlate_resp_o  (xlate_resp),
    .pte_wr_i      (pte_wr),
    .busy_o        (busy)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF_NS clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (mmu_top_i.ptw_walker_i.protocol_checks_i.error_count != 0) begin
      abort_run("a protocol assertion on the page table walker failed");
    end else if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles, the DUT stopped responding", cycle_cnt));
    end
  end

  // ====================================================================
  // helpers
  // ====================================================================

  task automatic abort_run(input string reason);
    $display("%0s", reason);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_value(input logic [TOKEN_W-1:0] test, input string field,
                              input logic [63:0] expected, input logic [63:0] actual);
    abort_run($sformatf("ERROR %0s: %0s expected %0h, actual %0h",
                        test, field, expected, actual));
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #DRIVE_DELAY_NS;  // inputs change well after the edge.
  endtask

  task automatic load_trace();
    int                 fd;
    logic [LINE_W-1:0]  line;
    logic [TOKEN_W-1:0] tok;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      abort_run("cannot open the trace file tests/mmu_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        tok  = '0;
        if ($fgets(line, fd) > 0) begin
          if ($sscanf(line, "%s", tok) == 1 && tok != "#") begin
            rec_q.push_back(line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic apply_config(input logic [LINE_W-1:0] line);
    logic [TOKEN_W-1:0] tok;
    logic [63:0]        satp_v, priv_v, sum_v, mxr_v;
    if ($sscanf(line, "%s %h %h %h %h", tok, satp_v, priv_v, sum_v, mxr_v) != 5) begin
      abort_run("malformed C record in the trace file");
    end
    satp_ppn  = satp_v[PPN_W-1:0];
    priv_mode = priv_v[PRIV_W-1:0];
    sum       = sum_v[0];
    mxr       = mxr_v[0];
    next_cycle();
  endtask

  task automatic write_pte(input logic [LINE_W-1:0] line);
    logic [TOKEN_W-1:0] tok;
    logic [63:0]        addr, data;
    if ($sscanf(line, "%s %h %h", tok, addr, data) != 3) begin
      abort_run("malformed W record in the trace file");
    end
    pte_wr = '{v: 1'b1, addr: addr[PT_WORD_AW-1:0], data: data};
    next_cycle();
    pte_wr.v = 1'b0;
  endtask

  task automatic flush_tlb();
    tlb_flush = 1'b1;
    next_cycle();
    tlb_flush = 1'b0;
  endtask

  task automatic run_translation(input logic [LINE_W-1:0] line);
    logic [TOKEN_W-1:0] tok, name, kind_s;
    logic [63:0]        vaddr, exp_paddr;
    logic               exp_fault, exp_hit;
    logic               saw_busy;
    access_e            acc;
    int                 latency;
    if ($sscanf(line, "%s %s %s %h %h %h %h", tok, name, kind_s, vaddr,
                exp_fault, exp_paddr, exp_hit) != 7) begin
      abort_run("malformed T record in the trace file");
    end
    if (kind_s == "fetch") begin
      acc = ACC_FETCH;
    end else if (kind_s == "load") begin
      acc = ACC_LOAD;
    end else if (kind_s == "store") begin
      acc = ACC_STORE;
    end else begin
      abort_run($sformatf("unknown access kind %0s in test %0s", kind_s, name));
    end
    while (!xlate_ready) begin
      next_cycle();
    end
    xlate_req = '{v: 1'b1, kind: acc, vaddr: vaddr[VADDR_W-1:0]};
    next_cycle();
    xlate_req.v = 1'b0;
    latency  = 1;
    saw_busy = busy;
    while (!xlate_resp.v) begin
      assert (!xlate_ready)
        else report_value(name, "ready while pending", 64'd0, 64'(xlate_ready));
      next_cycle();
      latency++;
      saw_busy |= busy;
    end
    assert (xlate_ready)
      else report_value(name, "ready after response", 64'd1, 64'(xlate_ready));
    assert (!busy)
      else report_value(name, "busy after response", 64'd0, 64'(busy));
    assert (saw_busy == !exp_hit)
      else report_value(name, "walker busy", 64'(!exp_hit), 64'(saw_busy));
    assert (xlate_resp.fault == exp_fault)
      else report_value(name, "fault", 64'(exp_fault), 64'(xlate_resp.fault));
    if (!exp_fault) begin
      assert (xlate_resp.paddr == exp_paddr[PADDR_W-1:0])
        else report_value(name, "paddr", exp_paddr, 64'(xlate_resp.paddr));
    end
    if (exp_hit) begin
      assert (latency == 1)
        else report_value(name, "latency", 64'd1, 64'(latency));
    end else begin
      assert (latency > 1)
        else abort_run($sformatf("ERROR %0s: answered in one cycle, a page walk was expected",
                                 name));
    end
  endtask

  task automatic run_record(input logic [LINE_W-1:0] line);
    logic [TOKEN_W-1:0] tok;
    tok = '0;
    void'($sscanf(line, "%s", tok));
    case (tok)
      "C":     apply_config(line);
      "W":     write_pte(line);
      "F":     flush_tlb();
      "T":     run_translation(line);
      default: abort_run($sformatf("unknown record type %0s in the trace file", tok));
    endcase
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================

  initial begin
    reset_i   = 1'b1;
    satp_ppn  = '0;
    priv_mode = PRIV_S;
    sum       = 1'b0;
    mxr       = 1'b0;
    tlb_flush = 1'b0;
    xlate_req = '0;
    pte_wr    = '0;
    load_trace();
    cycle_limit = CYCLES_PER_RECORD * rec_q.size() + RESET_CYCLES;
    repeat (RESET_CYCLES) next_cycle();
    reset_i = 1'b0;
    foreach (rec_q[i]) begin
      run_record(rec_q[i]);
    end
    next_cycle();
    if (mmu_top_i.ptw_walker_i.protocol_checks_i.error_count != 0) begin
      abort_run("a protocol assertion on the page table walker failed");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tests/mmu_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_assertions
  import ptw_pkg::*;
(
  input wire            clk_i,
  input wire            reset_i,
  input wire mem_req_t  mem_req_i,
  input wire            mem_tag_v_i,
  input wire            mem_ready_i,
  input wire ptw_fill_t fill_i
);

  int unsigned error_count = 0;

  logic any_fault;

  assign any_fault = fill_i.instr_fault_v | fill_i.load_fault_v | fill_i.store_fault_v;

  // ====================================================================
  // walker to memory
  // ====================================================================

  req_takes_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_i.v |=> !mem_ready_i)
    else begin
      error_count++;
      $error("memory still ready in the cycle after a request");
    end

  tag_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_i.v |=> mem_tag_v_i)
    else begin
      error_count++;
      $error("tag valid missing one cycle after a memory request");
    end

  tag_only_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_tag_v_i |-> $past(mem_req_i.v))
    else begin
      error_count++;
      $error("tag valid without a memory request in the previous cycle");
    end

  // ====================================================================
  // walker result
  // ====================================================================

  fill_or_fault: assert property (@(posedge clk_i) disable iff (reset_i)
    !(fill_i.fill_v && any_fault))
    else begin
      error_count++;
      $error("fill and page fault raised in the same cycle");
    end

endmodule

bind ptw_walker mmu_assertions protocol_checks_i (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .mem_req_i   (mem_req_o),
  .mem_tag_v_i (mem_tag_v_o),
  .mem_ready_i (mem_ready_i),
  .fill_i      (fill_o)
);

`default_nettype wire

// ==== hw/mmu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_top
  import ptw_pkg::*;
(
  input  wire               clk_i,
  input  wire               reset_i,

  input  wire [PPN_W-1:0]   satp_ppn_i,
  input  wire [PRIV_W-1:0]  priv_mode_i,
  input  wire               sum_i,
  input  wire               mxr_i,
  input  wire               tlb_flush_i,

  input  wire xlate_req_t   xlate_req_i,
  output logic              xlate_ready_o,
  output xlate_resp_t       xlate_resp_o,

  input  wire pte_wr_t      pte_wr_i,
  output logic              busy_o
);

  ptw_miss_t        miss;
  ptw_fill_t        fill;
  mem_req_t         mem_req;
  logic [PPN_W-1:0] mem_tag;
  logic             mem_tag_v;
  logic             mem_ready;
  logic             mem_data_v;
  sv39_pte_t        mem_data;

  tlb tlb_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .tlb_flush_i (tlb_flush_i),
    .req_i       (xlate_req_i),
    .ready_o     (xlate_ready_o),
    .resp_o      (xlate_resp_o),
    .miss_o      (miss),
    .fill_i      (fill)
  );

  ptw_walker ptw_walker_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .satp_ppn_i   (satp_ppn_i),
    .priv_mode_i  (priv_mode_i),
    .sum_i        (sum_i),
    .mxr_i        (mxr_i),
    .busy_o       (busy_o),
    .miss_i       (miss),
    .fill_o       (fill),
    .mem_req_o    (mem_req),
    .mem_tag_o    (mem_tag),
    .mem_tag_v_o  (mem_tag_v),
    .mem_ready_i  (mem_ready),
    .mem_data_v_i (mem_data_v),
    .mem_data_i   (mem_data)
  );

  // stands in for the data cache.
  pt_mem pt_mem_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (mem_req),
    .ready_o  (mem_ready),
    .tag_i    (mem_tag),
    .tag_v_i  (mem_tag_v),
    .data_v_o (mem_data_v),
    .data_o   (mem_data),
    .wr_i     (pte_wr_i)
  );

endmodule

`default_nettype wire

// ==== hw/ptw_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ptw_walker
  import ptw_pkg::*;
(
  input  wire                clk_i,
  input  wire                reset_i,

  input  wire [PPN_W-1:0]    satp_ppn_i,
  input  wire [PRIV_W-1:0]   priv_mode_i,
  input  wire                sum_i,
  input  wire                mxr_i,
  output logic               busy_o,

  input  wire ptw_miss_t     miss_i,
  output ptw_fill_t          fill_o,

  output mem_req_t           mem_req_o,
  output logic [PPN_W-1:0]   mem_tag_o,
  output logic               mem_tag_v_o,
  input  wire                mem_ready_i,

  input  wire                mem_data_v_i,
  input  wire sv39_pte_t     mem_data_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND,
    ST_WAIT,
    ST_RECV,
    ST_WRITEBACK
  } state_e;

  state_e state_r, state_n;

  ptw_miss_t                         miss_r;
  logic                              start;
  logic                              eval;
  logic [LEVEL_W-1:0]                level_r;
  logic [PPN_W-1:0]                  ppn_r;
  sv39_pte_t                         pte_r;
  logic                              pte_v_r;

  logic [VPN_W-1:0]                  vpn;
  logic [LEVELS-1:0][PAGE_IDX_W-1:0] vpn_slice;
  logic [LEVELS-2:0]                 misaligned_bits;
  logic [PPN_W-1:0]                  leaf_ppn;
  tlb_entry_t                        entry;

  logic is_fetch, is_load, is_store;
  logic is_leaf, pte_invalid, leaf_not_found;
  logic priv_fault, misaligned, ad_fault, common_fault, any_fault;

  assign start  = (state_r == ST_IDLE) & miss_i.v;
  assign busy_o = (state_r != ST_IDLE);
  assign eval   = (state_r == ST_RECV) & pte_v_r;  // registered pte is here.

  assign vpn = miss_r.vaddr[VADDR_W-1 -: VPN_W];

  for (genvar i = 0; i < LEVELS; i++) begin : g_vpn
    assign vpn_slice[i] = vpn[i*PAGE_IDX_W +: PAGE_IDX_W];
  end

  // superpages take their low ppn bits from the virtual address.
  for (genvar i = 0; i < LEVELS-1; i++) begin : g_super
    assign misaligned_bits[i] = (level_r > i) & (|pte_r.ppn[i*PAGE_IDX_W +: PAGE_IDX_W]);
    assign leaf_ppn[i*PAGE_IDX_W +: PAGE_IDX_W] =
      (level_r > i) ? vpn_slice[i] : ppn_r[i*PAGE_IDX_W +: PAGE_IDX_W];
  end
  assign leaf_ppn[PPN_W-1:(LEVELS-1)*PAGE_IDX_W] = ppn_r[PPN_W-1:(LEVELS-1)*PAGE_IDX_W];

  // ======================================================================
  // memory side
  // ======================================================================

  assign mem_req_o.v           = mem_ready_i & (state_r == ST_SEND);
  assign mem_req_o.page_offset = {vpn_slice[level_r], {PTE_BYTES_LG{1'b0}}};
  assign mem_tag_o             = ppn_r;
  assign mem_tag_v_o           = (state_r == ST_WAIT);

  // ======================================================================
  // pte checks
  // ======================================================================

  assign is_fetch = (miss_r.kind == ACC_FETCH);
  assign is_load  = (miss_r.kind == ACC_LOAD);
  assign is_store = (miss_r.kind == ACC_STORE);

  assign is_leaf        = pte_r.r | pte_r.w | pte_r.x;
  assign pte_invalid    = ~pte_r.v | (pte_r.w & ~pte_r.r);
  assign leaf_not_found = (level_r == '0) & ~is_leaf;
  assign priv_fault     = is_leaf
    & ((pte_r.u & (priv_mode_i == PRIV_S) & (is_fetch | ~sum_i))
       | (~pte_r.u & (priv_mode_i == PRIV_U)));
  assign misaligned     = is_leaf & (|misaligned_bits);
  assign ad_fault       = is_leaf & (~pte_r.a | (is_store & ~pte_r.d));
  assign common_fault   = pte_invalid | leaf_not_found | priv_fault | misaligned | ad_fault;

  assign fill_o.instr_fault_v = eval & is_fetch
    & (common_fault | (is_leaf & ~pte_r.x));
  assign fill_o.load_fault_v  = eval & is_load
    & (common_fault | (is_leaf & ~(pte_r.r | (pte_r.x & mxr_i))));
  assign fill_o.store_fault_v = eval & is_store
    & (common_fault | (is_leaf & ~pte_r.w));
  assign any_fault = fill_o.instr_fault_v | fill_o.load_fault_v | fill_o.store_fault_v;

  assign entry.ptag = leaf_ppn;
  assign entry.a    = pte_r.a;
  assign entry.d    = pte_r.d;
  assign entry.u    = pte_r.u;
  assign entry.x    = pte_r.x;
  assign entry.w    = pte_r.w;
  assign entry.r    = pte_r.r;

  assign fill_o.fill_v = (state_r == ST_WRITEBACK);
  assign fill_o.vaddr  = miss_r.vaddr;
  assign fill_o.entry  = entry;
  assign fill_o.level  = level_r;

  always_comb begin
    state_n = state_r;
    case (state_r)
      ST_IDLE:      state_n = start ? ST_SEND : ST_IDLE;
      ST_SEND:      state_n = mem_ready_i ? ST_WAIT : ST_SEND;
      ST_WAIT:      state_n = ST_RECV;
      ST_RECV: begin
        if (pte_v_r) begin
          if (any_fault) begin
            state_n = ST_IDLE;
          end else begin
            state_n = is_leaf ? ST_WRITEBACK : ST_SEND;
          end
        end
      end
      ST_WRITEBACK: state_n = ST_IDLE;
      default:      state_n = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ST_IDLE;
      level_r <= '0;
      pte_v_r <= 1'b0;
    end else begin
      state_r <= state_n;
      pte_v_r <= mem_data_v_i;
      if (start) begin
        level_r <= LEVEL_W'(LEVELS-1);
      end else if (eval & ~is_leaf & ~any_fault) begin
        level_r <= level_r - 1'b1;  // descend one level.
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      miss_r <= miss_i;
      ppn_r  <= satp_ppn_i;
    end else if (eval) begin
      ppn_r  <= pte_r.ppn;
    end
    if (mem_data_v_i) begin
      pte_r <= mem_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/tlb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb
  import ptw_pkg::*;
(
  input  wire              clk_i,
  input  wire              reset_i,
  input  wire              tlb_flush_i,

  input  wire xlate_req_t  req_i,
  output logic             ready_o,
  output xlate_resp_t      resp_o,

  output ptw_miss_t        miss_o,
  input  wire ptw_fill_t   fill_i
);

  typedef struct packed {
    logic [VPN_W-1:0]   vtag;
    logic [LEVEL_W-1:0] level;
    tlb_entry_t         entry;
  } slot_t;

  slot_t                  slot_r [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] valid_r;
  logic [TLB_IDX_W-1:0]   victim_r;

  logic                   pending_r;
  logic                   miss_v_r;
  access_e                req_kind_r;
  logic [VADDR_W-1:0]     req_vaddr_r;
  logic                   stale_r;  // request hit but failed the check.
  logic [TLB_IDX_W-1:0]   stale_idx_r;

  logic                   resp_v_r;
  logic [PADDR_W-1:0]     resp_paddr_r;
  logic                   resp_fault_r;

  logic [VPN_W-1:0]       req_vpn, fill_vpn;
  logic                   hit, hit_ok, accept, fault;
  logic [TLB_IDX_W-1:0]   hit_idx, fill_idx;
  slot_t                  hit_slot;

  function automatic logic vpn_match(input logic [VPN_W-1:0]   tag,
                                     input logic [LEVEL_W-1:0] lvl,
                                     input logic [VPN_W-1:0]   vpn);
    logic match;
    match = 1'b1;
    for (int l = 0; l < LEVELS; l++) begin
      if (l >= lvl && tag[l*PAGE_IDX_W +: PAGE_IDX_W] != vpn[l*PAGE_IDX_W +: PAGE_IDX_W]) begin
        match = 1'b0;
      end
    end
    return match;
  endfunction

  function automatic logic [PPN_W-1:0] map_ppn(input logic [PPN_W-1:0]   ptag,
                                               input logic [LEVEL_W-1:0] lvl,
                                               input logic [VPN_W-1:0]   vpn);
    logic [PPN_W-1:0] ppn;
    ppn = ptag;
    for (int l = 0; l < LEVELS-1; l++) begin
      if (l < lvl) begin
        ppn[l*PAGE_IDX_W +: PAGE_IDX_W] = vpn[l*PAGE_IDX_W +: PAGE_IDX_W];
      end
    end
    return ppn;
  endfunction

  // same leaf rules as the walker, minus privilege and mxr.
  function automatic logic perm_ok(input tlb_entry_t e, input access_e kind);
    logic ok;
    case (kind)
      ACC_FETCH: ok = e.x;
      ACC_LOAD:  ok = e.r;
      ACC_STORE: ok = e.w & e.d;
      default:   ok = 1'b0;
    endcase
    return ok & e.a;
  endfunction

  assign req_vpn  = req_i.vaddr[VADDR_W-1 -: VPN_W];
  assign fill_vpn = fill_i.vaddr[VADDR_W-1 -: VPN_W];

  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (valid_r[i] && vpn_match(slot_r[i].vtag, slot_r[i].level, req_vpn)) begin
        hit     = 1'b1;
        hit_idx = TLB_IDX_W'(i);
      end
    end
  end

  assign hit_slot = slot_r[hit_idx];
  assign hit_ok   = hit & perm_ok(hit_slot.entry, req_i.kind);
  assign ready_o  = ~pending_r;
  assign accept   = req_i.v & ready_o;
  assign fault    = fill_i.instr_fault_v | fill_i.load_fault_v | fill_i.store_fault_v;
  assign fill_idx = stale_r ? stale_idx_r : victim_r;  // no duplicate tags.

  assign miss_o.v     = miss_v_r;  // walker is idle whenever this rises.
  assign miss_o.kind  = req_kind_r;
  assign miss_o.vaddr = req_vaddr_r;

  assign resp_o.v     = resp_v_r;
  assign resp_o.paddr = resp_paddr_r;
  assign resp_o.fault = resp_fault_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_r <= 1'b0;
      miss_v_r  <= 1'b0;
      resp_v_r  <= 1'b0;
      valid_r   <= '0;
      victim_r  <= '0;
    end else begin
      miss_v_r <= accept & ~hit_ok;
      resp_v_r <= (accept & hit_ok) | fill_i.fill_v | fault;
      if (accept & ~hit_ok) begin
        pending_r <= 1'b1;
      end else if (fill_i.fill_v | fault) begin
        pending_r <= 1'b0;
      end
      if (tlb_flush_i) begin
        valid_r <= '0;
      end else if (fill_i.fill_v) begin
        valid_r[fill_idx] <= 1'b1;
      end
      if (fill_i.fill_v & ~stale_r) begin
        victim_r <= victim_r + 1'b1;  // round robin.
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_kind_r   <= req_i.kind;
      req_vaddr_r  <= req_i.vaddr;
      stale_r      <= hit;
      stale_idx_r  <= hit_idx;
      resp_paddr_r <= {map_ppn(hit_slot.entry.ptag, hit_slot.level, req_vpn),
                       req_i.vaddr[PAGE_OFF_W-1:0]};
      resp_fault_r <= 1'b0;
    end else if (fill_i.fill_v) begin
      resp_paddr_r <= {fill_i.entry.ptag, fill_i.vaddr[PAGE_OFF_W-1:0]};
      resp_fault_r <= 1'b0;
    end else if (fault) begin
      resp_paddr_r <= '0;
      resp_fault_r <= 1'b1;
    end
    if (fill_i.fill_v) begin
      slot_r[fill_idx] <= '{vtag: fill_vpn, level: fill_i.level, entry: fill_i.entry};
    end
  end

endmodule

`default_nettype wire

// ==== hw/pt_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module pt_mem
  import ptw_pkg::*;
(
  input  wire              clk_i,
  input  wire              reset_i,

  input  wire mem_req_t    req_i,
  output logic             ready_o,
  input  wire [PPN_W-1:0]  tag_i,
  input  wire              tag_v_i,

  output logic             data_v_o,
  output sv39_pte_t        data_o,

  input  wire pte_wr_t     wr_i
);

  sv39_pte_t             mem [2**PT_WORD_AW];
  logic [PAGE_IDX_W-1:0] idx_r;  // pte index within the page.
  logic                  inflight_r;
  logic                  data_v_r;
  sv39_pte_t             data_r;
  logic [PT_WORD_AW-1:0] rd_addr;

  // low tag bits pick one of the modelled pages.
  assign rd_addr  = {tag_i[PT_PAGES_LG-1:0], idx_r};
  assign ready_o  = ~inflight_r & ~wr_i.v;
  assign data_v_o = data_v_r;
  assign data_o   = data_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inflight_r <= 1'b0;
      data_v_r   <= 1'b0;
    end else begin
      data_v_r <= tag_v_i & inflight_r;
      if (req_i.v) begin
        inflight_r <= 1'b1;
      end else if (data_v_r) begin
        inflight_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.v) begin
      idx_r <= req_i.page_offset[PAGE_OFF_W-1:PTE_BYTES_LG];
    end
    if (tag_v_i) begin
      data_r <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_i.v) begin
      mem[wr_i.addr] <= wr_i.data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/ptw_pkg.sv ====
`default_nettype none

package ptw_pkg;

  // ======================================================================
  // sv39 geometry
  // ======================================================================

  localparam int VADDR_W      = 39;
  localparam int PADDR_W      = 56;
  localparam int PPN_W        = 44;
  localparam int VPN_W        = 27;
  localparam int PAGE_IDX_W   = 9;
  localparam int PAGE_OFF_W   = 12;
  localparam int LEVELS       = 3;
  localparam int LEVEL_W      = 2;
  localparam int PTE_BYTES_LG = 3;

  localparam int TLB_ENTRIES  = 8;
  localparam int TLB_IDX_W    = $clog2(TLB_ENTRIES);

  localparam int PT_PAGES_LG  = 3;
  localparam int PT_WORD_AW   = PT_PAGES_LG + PAGE_IDX_W;  // 4096 ptes.

  localparam int PRIV_W = 2;
  localparam logic [PRIV_W-1:0] PRIV_S = 2'd1;
  localparam logic [PRIV_W-1:0] PRIV_U = 2'd0;

  typedef enum logic [1:0] {
    ACC_FETCH = 2'd0,
    ACC_LOAD  = 2'd1,
    ACC_STORE = 2'd2
  } access_e;

  // ======================================================================
  // page table entry and translation packets
  // ======================================================================

  typedef struct packed {
    logic [9:0]       reserved;
    logic [PPN_W-1:0] ppn;
    logic [1:0]       rsw;
    logic             d;
    logic             a;
    logic             g;
    logic             u;
    logic             x;
    logic             w;
    logic             r;
    logic             v;
  } sv39_pte_t;

  typedef struct packed {
    logic               v;
    access_e            kind;
    logic [VADDR_W-1:0] vaddr;
  } xlate_req_t;

  typedef struct packed {
    logic               v;
    logic [PADDR_W-1:0] paddr;
    logic               fault;
  } xlate_resp_t;

  typedef struct packed {
    logic               v;
    access_e            kind;
    logic [VADDR_W-1:0] vaddr;
  } ptw_miss_t;

  typedef struct packed {
    logic [PPN_W-1:0] ptag;
    logic             a;
    logic             d;
    logic             u;
    logic             x;
    logic             w;
    logic             r;
  } tlb_entry_t;

  typedef struct packed {
    logic               fill_v;
    logic               instr_fault_v;
    logic               load_fault_v;
    logic               store_fault_v;
    logic [VADDR_W-1:0] vaddr;
    tlb_entry_t         entry;
    logic [LEVEL_W-1:0] level;  // 0 page, 1 mega, 2 giga.
  } ptw_fill_t;

  typedef struct packed {
    logic                  v;
    logic [PAGE_OFF_W-1:0] page_offset;
  } mem_req_t;

  typedef struct packed {
    logic                  v;
    logic [PT_WORD_AW-1:0] addr;  // word address.
    sv39_pte_t             data;
  } pte_wr_t;

endpackage

`default_nettype wire
